/* Makefile */
TOOL  := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := tb_keccak
FLIST := flist.f
BIN   := obj_dir/V$(TOP)
LOG   := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
+incdir+sim
rtl/keccak_pkg.sv
rtl/rconst.sv
rtl/round.sv
rtl/f_permutation.sv
rtl/padder.sv
rtl/keccak_top.sv
sim/tb_keccak.sv

/* rtl/f_permutation.sv */
/* keccak-f[1600] permutation engine.
   absorbs a rate block on ack and runs one round per clock for 24 clocks. */

`timescale 1ns/1ps

module f_permutation (
    input  logic               clk,
    input  logic               reset,
    input  keccak_pkg::block_t in,
    input  logic               in_ready,
    output logic               ack,
    output keccak_pkg::state_t out,
    output logic               out_ready
);
    logic [keccak_pkg::NUM_ROUNDS-2:0] i;     // one-hot marker for rounds 2 to 24.
    logic                              calc;  // rounds in progress.
    logic                              accept;
    logic                              update;
    logic                              last_round;
    keccak_pkg::round_idx_t            round_idx;
    keccak_pkg::rc_t                   rc;
    keccak_pkg::state_t                round_in;
    keccak_pkg::state_t                round_out;

    assign accept     = in_ready & ~calc;           // take a block only when idle.
    assign ack        = accept;
    assign update     = calc | accept;
    assign last_round = i[keccak_pkg::NUM_ROUNDS-2];
    assign round_idx  = {i, accept};                // the accept cycle is round 1.

    always_ff @(posedge clk) begin
        if (reset) begin
            i         <= '0;
            calc      <= 1'b0;
            out_ready <= 1'b0;
        end else begin
            i    <= {i[keccak_pkg::NUM_ROUNDS-3:0], accept}; // shift the marker along.
            calc <= (calc & ~last_round) | accept;
            if (accept) begin
                out_ready <= 1'b0;                   // new block, old result gone.
            end else if (last_round) begin
                out_ready <= 1'b1;                   // round 24 lands this edge.
            end
        end
    end

    // xor the block into the rate lanes on the accept cycle only.
    assign round_in = accept ?
        {in ^ out[keccak_pkg::STATE_W-1 -: keccak_pkg::RATE_W],
         out[keccak_pkg::STATE_W-keccak_pkg::RATE_W-1:0]} : out;

    rconst rconst_inst (
        .round (round_idx),
        .rc    (rc)
    );

    round round_inst (
        .in  (round_in),
        .rc  (rc),
        .out (round_out)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            out <= '0;
        end else if (update) begin
            out <= round_out;
        end
    end

    // the padder never sees an ack while a round marker is live.
    assert property (@(posedge clk) disable iff (reset) !(ack && (i != '0)));
    assert property (@(posedge clk) disable iff (reset) $onehot0(i));
    // a result is never reported while rounds still run.
    assert property (@(posedge clk) disable iff (reset) !(out_ready && calc));

endmodule

/* rtl/keccak_pkg.sv */
/* keccak core package.
   widths, lane types, rate constants and the padder sequencer states for sha3-512. */

package keccak_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int LANE_W       = 64;                    // bits per lane.
    localparam int NUM_LANES    = 25;                    // 5 x 5 lanes.
    localparam int STATE_W      = NUM_LANES * LANE_W;    // 1600.
    localparam int RATE_LANES   = 9;                     // sha3-512 rate, 576 bits.
    localparam int RATE_W       = RATE_LANES * LANE_W;
    localparam int DIGEST_LANES = 8;
    localparam int DIGEST_W     = DIGEST_LANES * LANE_W; // 512.
    localparam int NUM_ROUNDS   = 24;

    // rho rotation offsets, indexed by lane x+5y.
    localparam int unsigned RHO_OFS [NUM_LANES] = '{
         0,  1, 62, 28, 27,
        36, 44,  6, 55, 20,
         3, 10, 43, 25, 39,
        41, 45, 15, 21,  8,
        18,  2, 61, 56, 14
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // types. lane 0 sits in the top bits of every wide vector.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [STATE_W-1:0]    state_t;     // full keccak state.
    typedef logic [LANE_W-1:0]     lane_t;      // one lane, byte 0 in bits 7:0.
    typedef logic [RATE_W-1:0]     block_t;     // lanes 0 to 8.
    typedef logic [DIGEST_W-1:0]   digest_t;    // lanes 0 to 7.
    typedef logic [2:0]            byte_cnt_t;  // valid bytes in the last word.
    typedef logic [3:0]            lane_cnt_t;  // lanes held in the padder, 0 to 9.
    typedef logic [NUM_ROUNDS-1:0] round_idx_t; // one-hot, bit r means round r+1.
    typedef logic [LANE_W-1:0]     rc_t;        // iota round constant.

    // padder sequencer.
    typedef enum logic [1:0] {
        collect,  // taking words.
        pad,      // closing the last block.
        hand_off, // block waits for the permutation.
        finished  // message done, idle until the next word.
    } padder_state_t;

endpackage

/* rtl/keccak_top.sv */
/* sha3-512 core top.
   padder feeding the keccak-f permutation, digest taken from the top 512 state bits. */

`timescale 1ns/1ps

module keccak_top (
    input  logic                  clk,
    input  logic                  reset,
    input  keccak_pkg::lane_t     in,
    input  logic                  in_valid,
    input  logic                  is_last,
    input  keccak_pkg::byte_cnt_t byte_num,
    output logic                  buffer_full,
    output keccak_pkg::digest_t   out,
    output logic                  out_ready
);
    keccak_pkg::block_t blk;        // padded block to the permutation.
    logic               blk_ready;
    logic               ack;
    logic               last_block;
    keccak_pkg::state_t state;
    logic               perm_ready;
    logic               final_seen; // final block taken, digest pending or shown.
    logic               perm_reset; // permutation back to a zero state.

    // the next message starts from a zero state.
    assign perm_reset = reset | (final_seen & in_valid & ~buffer_full);

    padder padder_inst (
        .clk         (clk),
        .reset       (reset),
        .in          (in),
        .in_valid    (in_valid),
        .is_last     (is_last),
        .byte_num    (byte_num),
        .buffer_full (buffer_full),
        .out         (blk),
        .out_ready   (blk_ready),
        .ack         (ack),
        .last_block  (last_block)
    );

    f_permutation f_permutation_inst (
        .clk       (clk),
        .reset     (perm_reset),
        .in        (blk),
        .in_ready  (blk_ready),
        .ack       (ack),
        .out       (state),
        .out_ready (perm_ready)
    );

    // perm_ready drops on the final ack, so its next rise belongs to that block.
    always_ff @(posedge clk) begin
        if (reset) begin
            final_seen <= 1'b0;
        end else if (ack && last_block) begin
            final_seen <= 1'b1;
        end else if (in_valid && !buffer_full) begin
            final_seen <= 1'b0;                 // first word of the next message.
        end
    end

    assign out_ready = final_seen & perm_ready;
    assign out       = state[keccak_pkg::STATE_W-1 -: keccak_pkg::DIGEST_W];

    // a shown digest holds until the host starts a new message.
    assert property (@(posedge clk) disable iff (reset)
        (out_ready && !(in_valid && !buffer_full)) |=> out_ready);

endmodule

/* rtl/padder.sv */
/* sha-3 padder.
   packs 64-bit words into 576-bit blocks, applies 0x06 ... 0x80 padding and
   hands each block to the permutation. */

`timescale 1ns/1ps

module padder (
    input  logic                  clk,
    input  logic                  reset,
    input  keccak_pkg::lane_t     in,
    input  logic                  in_valid,
    input  logic                  is_last,
    input  keccak_pkg::byte_cnt_t byte_num,
    output logic                  buffer_full,
    output keccak_pkg::block_t    out,
    output logic                  out_ready,
    input  logic                  ack,
    output logic                  last_block
);
    keccak_pkg::padder_state_t state;
    keccak_pkg::block_t        blk_q;     // lanes shift in from the bottom.
    keccak_pkg::lane_cnt_t     cnt;       // lanes stored so far.
    logic                      accept;
    logic [5:0]                bit_pos;   // first bit of the 0x06 byte.
    keccak_pkg::lane_t         keep_mask;
    keccak_pkg::lane_t         last_word;
    keccak_pkg::lane_t         word_in;
    keccak_pkg::block_t        padded;

    assign buffer_full = (state == keccak_pkg::pad) || (state == keccak_pkg::hand_off);
    assign out_ready   = (state == keccak_pkg::hand_off);
    assign out         = blk_q;
    assign accept      = in_valid && !buffer_full;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // padding datapath.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign bit_pos   = {byte_num, 3'b000};
    assign keep_mask = (keccak_pkg::lane_t'(1) << bit_pos) - keccak_pkg::lane_t'(1);
    assign last_word = (in & keep_mask) | (keccak_pkg::lane_t'(8'h06) << bit_pos);
    assign word_in   = is_last ? last_word : in;

    // push the stored lanes to the top, zero fill below, 0x80 into the top byte
    // of lane 8. with 71 bytes that byte already holds 0x06 and becomes 0x86.
    assign padded = (blk_q << (keccak_pkg::LANE_W * (keccak_pkg::RATE_LANES - int'(cnt)))) |
                    keccak_pkg::block_t'(64'h8000_0000_0000_0000);

    always_ff @(posedge clk) begin
        if (accept) begin
            blk_q <= {blk_q[keccak_pkg::RATE_W-keccak_pkg::LANE_W-1:0], word_in};
        end else if (state == keccak_pkg::pad) begin
            blk_q <= padded;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // absorb / pad sequencer.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= keccak_pkg::collect;
            cnt        <= '0;
            last_block <= 1'b0;
        end else begin
            case (state)
                keccak_pkg::collect, keccak_pkg::finished: begin
                    if (accept) begin
                        cnt <= keccak_pkg::lane_cnt_t'(cnt + 1'b1);
                        if (is_last) begin
                            state <= keccak_pkg::pad;      // close the block next cycle.
                        end else if (cnt == keccak_pkg::lane_cnt_t'(keccak_pkg::RATE_LANES-1)) begin
                            state <= keccak_pkg::hand_off; // 9th lane, block full.
                        end else begin
                            state <= keccak_pkg::collect;
                        end
                    end
                end
                keccak_pkg::pad: begin
                    state      <= keccak_pkg::hand_off;
                    last_block <= 1'b1;
                end
                keccak_pkg::hand_off: begin
                    if (ack) begin
                        cnt        <= '0;
                        last_block <= 1'b0;
                        state      <= last_block ? keccak_pkg::finished : keccak_pkg::collect;
                    end
                end
                default: state <= keccak_pkg::collect;
            endcase
        end
    end

    // the host holds off while the buffer is full.
    assert property (@(posedge clk) disable iff (reset) buffer_full |-> !in_valid);
    // the block stays put until the permutation takes it.
    assert property (@(posedge clk) disable iff (reset)
        (out_ready && !ack) |=> (out_ready && $stable(out)));

endmodule

/* rtl/rconst.sv */
/* keccak round constant.
   decodes the one-hot round index into the 64-bit iota constant. */

`timescale 1ns/1ps

module rconst (
    input  keccak_pkg::round_idx_t round,
    output keccak_pkg::rc_t        rc
);
    // only bits 0, 1, 3, 7, 15, 31 and 63 are ever set.
    always_comb begin
        rc = '0;
        rc[0]  = round[0] | round[4] | round[5] | round[6] | round[7] | round[10] |
                 round[12] | round[13] | round[14] | round[15] | round[20] | round[22];
        rc[1]  = round[1] | round[2] | round[4] | round[8] | round[11] | round[12] |
                 round[13] | round[15] | round[16] | round[18] | round[19];
        rc[3]  = round[2] | round[4] | round[7] | round[8] | round[9] | round[10] |
                 round[11] | round[12] | round[13] | round[14] | round[18] | round[19] |
                 round[23];
        rc[7]  = round[1] | round[2] | round[4] | round[6] | round[8] | round[9] |
                 round[12] | round[13] | round[14] | round[17] | round[20] | round[21];
        rc[15] = round[1] | round[2] | round[3] | round[4] | round[6] | round[7] |
                 round[10] | round[12] | round[14] | round[15] | round[16] | round[18] |
                 round[20] | round[21] | round[23];
        rc[31] = round[3] | round[5] | round[6] | round[10] | round[11] | round[12] |
                 round[19] | round[20] | round[22] | round[23];
        rc[63] = round[2] | round[3] | round[6] | round[7] | round[13] | round[14] |
                 round[15] | round[16] | round[17] | round[19] | round[20] | round[21] |
                 round[23];
    end

endmodule

/* rtl/round.sv */
/* one keccak-f[1600] round.
   theta, rho, pi, chi and iota in a single combinational pass over the state. */

`timescale 1ns/1ps

module round (
    input  keccak_pkg::state_t in,
    input  keccak_pkg::rc_t    rc,
    output keccak_pkg::state_t out
);
    keccak_pkg::lane_t a  [keccak_pkg::NUM_LANES]; // input lanes.
    keccak_pkg::lane_t ta [keccak_pkg::NUM_LANES]; // after theta.
    keccak_pkg::lane_t b  [keccak_pkg::NUM_LANES]; // after rho and pi.
    keccak_pkg::lane_t o  [keccak_pkg::NUM_LANES]; // after chi.
    keccak_pkg::lane_t c  [5];                     // column parities.
    keccak_pkg::lane_t d  [5];                     // theta mix terms.

    // left rotate toward higher bit index, n in 0..63.
    function automatic keccak_pkg::lane_t rotl(keccak_pkg::lane_t v, int unsigned n);
        return (v << n) | (v >> ((keccak_pkg::LANE_W - n) % keccak_pkg::LANE_W));
    endfunction

    // unpack, lane 0 from the top.
    always_comb begin
        for (int k = 0; k < keccak_pkg::NUM_LANES; k++) begin
            a[k] = in[keccak_pkg::STATE_W-1-keccak_pkg::LANE_W*k -: keccak_pkg::LANE_W];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // theta.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int x = 0; x < 5; x++) begin
            c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
        end
        for (int x = 0; x < 5; x++) begin
            d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1); // left neighbour, right rotated.
        end
        for (int k = 0; k < keccak_pkg::NUM_LANES; k++) begin
            ta[k] = a[k] ^ d[k%5];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rho and pi. b[x,y] takes a[(x+3y)%5, x], rotated by that lane's offset.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int y = 0; y < 5; y++) begin
            for (int x = 0; x < 5; x++) begin
                b[x+5*y] = rotl(ta[(x+3*y)%5 + 5*x],
                                keccak_pkg::RHO_OFS[(x+3*y)%5 + 5*x]);
            end
        end
    end

    // chi, row-wise nonlinear step.
    always_comb begin
        for (int y = 0; y < 5; y++) begin
            for (int x = 0; x < 5; x++) begin
                o[x+5*y] = b[x+5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]);
            end
        end
    end

    // iota on lane 0, then repack.
    always_comb begin
        for (int k = 0; k < keccak_pkg::NUM_LANES; k++) begin
            out[keccak_pkg::STATE_W-1-keccak_pkg::LANE_W*k -: keccak_pkg::LANE_W] =
                (k == 0) ? (o[k] ^ rc) : o[k];
        end
    end

endmodule

/* sim/keccak_model.svh */
/* sha3-512 reference model.
   keccak-f[1600] over a lane array and sha3-512 over a byte queue, packed like the core. */

`ifndef KECCAK_MODEL_SVH
`define KECCAK_MODEL_SVH

typedef logic [7:0] byte_q_t [$];                                         // message bytes.
typedef keccak_pkg::lane_t [keccak_pkg::NUM_LANES-1:0] lanes_t;           // lane x+5y at [x+5y].

function automatic keccak_pkg::lane_t rotate_left(keccak_pkg::lane_t v, int n);
    return (n == 0) ? v : ((v << n) | (v >> (64 - n)));
endfunction

// rho offsets from the (x,y) -> (y,2x+3y) walk, t-th step gets (t+1)(t+2)/2.
function automatic int rho_offset(int lane);
    int x;
    int y;
    int old_x;
    x = 1;
    y = 0;
    for (int t = 0; t < 24; t++) begin
        if (x + 5 * y == lane) begin
            return ((t + 1) * (t + 2) / 2) % 64;
        end
        old_x = x;
        x = y;
        y = (2 * old_x + 3 * y) % 5;
    end
    return 0; // lane 0 is never rotated.
endfunction

// round constants from the x^8+x^6+x^5+x^4+1 lfsr, seven bits per round.
function automatic keccak_pkg::rc_t round_constant(int r);
    logic [7:0]      lfsr;
    keccak_pkg::rc_t rc;
    lfsr = 8'h01;
    rc   = '0;
    for (int k = 0; k <= r; k++) begin
        rc = '0;
        for (int j = 0; j < 7; j++) begin
            if (lfsr[0]) begin
                rc[(1 << j) - 1] = 1'b1;
            end
            lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
        end
    end
    return rc;
endfunction

function automatic lanes_t keccak_f(lanes_t a);
    lanes_t            b;
    keccak_pkg::lane_t c [5];
    keccak_pkg::lane_t d [5];
    for (int r = 0; r < 24; r++) begin
        for (int x = 0; x < 5; x++) begin
            c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20]; // column parity.
        end
        for (int x = 0; x < 5; x++) begin
            d[x] = c[(x+4)%5] ^ rotate_left(c[(x+1)%5], 1);
        end
        for (int k = 0; k < 25; k++) begin
            a[k] = a[k] ^ d[k%5];
        end
        for (int y = 0; y < 5; y++) begin
            for (int x = 0; x < 5; x++) begin
                b[y + 5*((2*x+3*y)%5)] = rotate_left(a[x+5*y], rho_offset(x+5*y)); // rho, pi.
            end
        end
        for (int y = 0; y < 5; y++) begin
            for (int x = 0; x < 5; x++) begin
                a[x+5*y] = b[x+5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]); // chi.
            end
        end
        a[0] = a[0] ^ round_constant(r); // iota.
    end
    return a;
endfunction

function automatic keccak_pkg::digest_t sha3_512(byte_q_t msg);
    byte_q_t             p;
    lanes_t              a;
    keccak_pkg::digest_t d;
    p = msg;
    p.push_back(8'h06);                         // domain bits.
    while (p.size() % 72 != 0) begin
        p.push_back(8'h00);
    end
    p[p.size()-1] = p[p.size()-1] | 8'h80;      // closing bit, may land on the 0x06.
    a = '0;
    for (int blk = 0; blk < p.size() / 72; blk++) begin
        for (int k = 0; k < 72; k++) begin
            a[k/8][8*(k%8) +: 8] = a[k/8][8*(k%8) +: 8] ^ p[72*blk + k];
        end
        a = keccak_f(a);
    end
    for (int i = 0; i < keccak_pkg::DIGEST_LANES; i++) begin
        d[keccak_pkg::DIGEST_W-1-64*i -: 64] = a[i];  // lane 0 on top.
    end
    return d;
endfunction

`endif

/* sim/tb_keccak.sv */
/* sha3-512 core testbench.
   streams messages into the core and checks each digest against the reference model. */

`timescale 1ns/1ps

module tb_keccak;
    logic                  clk;
    logic                  reset;
    keccak_pkg::lane_t     in;
    logic                  in_valid;
    logic                  is_last;
    keccak_pkg::byte_cnt_t byte_num;
    logic                  buffer_full;
    keccak_pkg::digest_t   out;
    logic                  out_ready;

    `include "keccak_model.svh"

    int                  seed = 80365;
    int                  digest_errors = 0;
    int                  flag_errors = 0;
    int                  other_errors = 0;
    int                  digests_seen = 0;
    int                  wd_cycles = 0;
    string               names [$];         // test list, built at time zero.
    int                  lens [$];
    int                  idles [$];
    string               exp_names [$];     // pending digests, oldest first.
    keccak_pkg::digest_t exp_digests [$];
    logic                ready_q;

    keccak_top keccak_top_inst (
        .clk         (clk),
        .reset       (reset),
        .in          (in),
        .in_valid    (in_valid),
        .is_last     (is_last),
        .byte_num    (byte_num),
        .buffer_full (buffer_full),
        .out         (out),
        .out_ready   (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_digest(input string name, input keccak_pkg::digest_t exp,
                                input keccak_pkg::digest_t act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            digest_errors++;
        end
    endtask

    task automatic check_flag(input string name, input string flag, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("error %s: %s should be %0b here but is %0b", name, flag, exp, act);
            flag_errors++;
        end
    endtask

    task automatic add_test(input string name, input int len, input int max_idle);
        names.push_back(name);
        lens.push_back(len);
        idles.push_back(max_idle);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host side. every task starts and ends on a falling edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_word(input string name, input keccak_pkg::lane_t word,
                             input logic last, input keccak_pkg::byte_cnt_t nbytes);
        while (buffer_full) begin
            @(negedge clk);                     // hold off while the padder is full.
        end
        @(posedge clk);
        in       <= word;
        in_valid <= 1'b1;
        is_last  <= last;
        byte_num <= nbytes;
        @(posedge clk);                         // taken on this edge.
        in_valid <= 1'b0;
        is_last  <= 1'b0;
        @(negedge clk);
        check_flag(name, "out_ready", 1'b0, out_ready); // no digest while a message is open.
    endtask

    task automatic send_message(input string name, input int len, input int max_idle);
        byte_q_t           msg;
        keccak_pkg::lane_t word;
        int                nwords;
        msg = {};
        for (int k = 0; k < len; k++) begin
            msg.push_back(8'($random(seed)));
        end
        exp_names.push_back(name);
        exp_digests.push_back(sha3_512(msg));
        nwords = len / 8 + 1;                   // a full last word is followed by an empty one.
        for (int w = 0; w < nwords; w++) begin
            for (int b = 0; b < 8; b++) begin
                if (8 * w + b < len) begin
                    word[8*b +: 8] = msg[8*w + b];          // little-endian in the lane.
                end else begin
                    word[8*b +: 8] = 8'($random(seed));     // junk past the end.
                end
            end
            repeat ({$random(seed)} % (max_idle + 1)) @(negedge clk);
            send_word(name, word, w == nwords - 1, keccak_pkg::byte_cnt_t'(len % 8));
            // full after the 9th lane of a block and after the last word.
            check_flag(name, "buffer_full", (w == nwords - 1) || (w % 9 == 8), buffer_full);
        end
    endtask

    // compares on every rising edge of out_ready.
    initial begin : digest_monitor
        ready_q = 1'b0;
        forever begin
            @(negedge clk);
            if (out_ready === 1'b1 && !ready_q) begin
                if (exp_digests.size() == 0) begin
                    $display("a digest appeared with no message pending");
                    other_errors++;
                end else begin
                    check_digest(exp_names.pop_front(), exp_digests.pop_front(), out);
                end
                digests_seen++;
            end
            ready_q = (out_ready === 1'b1);
        end
    end

    initial begin : watchdog
        #1;
        #(wd_cycles * 8);
        $display("timeout after %0d cycles with %0d of %0d digests seen",
                 wd_cycles, digests_seen, lens.size());
        $display("errors: digest %0d, flag %0d, other %0d",
                 digest_errors, flag_errors, other_errors + 1);
        $display("Regression failed");
        $finish;
    end

    initial begin : main
        reset    = 1'b1;
        in       = '0;
        in_valid = 1'b0;
        is_last  = 1'b0;
        byte_num = '0;
        add_test("empty", 0, 0);
        for (int n = 1; n < 72; n++) begin
            add_test($sformatf("short_%0d", n), n, 0);          // every byte_num value.
        end
        add_test("merge_71", 71, 0);                            // 0x06 and 0x80 share a byte.
        add_test("pad_block_72", 72, 0);                        // all-padding second block.
        for (int k = 0; k < 6; k++) begin
            add_test($sformatf("multi_%0d", k), 73 + {$random(seed)} % 228, 3);
        end
        for (int t = 0; t < lens.size(); t++) begin
            wd_cycles += 40 * (lens[t] / 72 + 1);
        end
        wd_cycles += 200;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("after_reset", "out_ready", 1'b0, out_ready);
        for (int t = 0; t < lens.size(); t++) begin
            send_message(names[t], lens[t], idles[t]); // back to back, no reset between.
            wait (digests_seen == t + 1);
        end
        repeat (3) @(negedge clk);
        check_flag("ready_hold", "out_ready", 1'b1, out_ready); // level holds until new input.
        send_word("ready_drop", '0, 1'b0, '0);                  // first word of a new message.
        @(negedge clk);
        $display("errors: digest %0d, flag %0d, other %0d",
                 digest_errors, flag_errors, other_errors);
        if (digest_errors + flag_errors + other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
